/* Makefile */
# Verilator build and run for the registered RV32I decoder

VERILATOR ?= verilator
TB_TOP    ?= tb_rv_decode_top
RTL_TOP   ?= rv_decode_top
FILELIST  ?= rv_decode_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing

RTL_SRCS  ?= design/rv_decode_pkg.sv \
             design/inst_key_gen.sv \
             design/ctrl_rom.sv \
             design/ctrl_issue_stage.sv \
             design/rv_decode_top.sv

SIM_BIN   = $(BUILD_DIR)/V$(TB_TOP)
PASS_MSG  = TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/ctrl_issue_stage.sv */
// Issue stage resolving taken branches, flagging ebreak and registering the decoded result
`timescale 1ns/1ps

module ctrl_issue_stage
    import rv_decode_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,
    input  inst_t     inst,
    input  br_flags_t br,
    input  ctrl_t     table_ctrl,
    output logic      out_valid,
    output ctrl_t     ctrl,
    output logic      is_ebreak
);

    logic  is_branch;                                   // Conditional branch opcode
    logic  br_taken;                                    // Flag picked by funct3
    logic  ebreak_hit;
    ctrl_t resolved;                                    // Table word after branch patch

    assign is_branch  = (inst.r.opcode == OPC_BRANCH);
    assign ebreak_hit = (inst == EBREAK_WORD);          // Exact match, no partial decode

    always_comb begin
        case (inst.r.funct3)
            F3_BEQ:  br_taken = br.eq;
            F3_BLT:  br_taken = br.lt;
            F3_BLTU: br_taken = br.ltu;
            default: br_taken = 1'b0;                   // BNE/BGE not in table
        endcase
    end

    always_comb begin
        resolved = table_ctrl;
        if (is_branch && br_taken) begin
            resolved.pc_sel = PC_BRANCH;                // Otherwise table keeps PC_SEQ
        end
    end

    // One stage; idle cycles clear the word so nothing stale is seen
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            ctrl      <= '0;
            is_ebreak <= 1'b0;
        end else begin
            out_valid <= in_valid;
            ctrl      <= in_valid ? resolved : '0;
            is_ebreak <= in_valid & ebreak_hit;
        end
    end

    // Branch target only for a branch accepted the cycle before
    a_branch_src: assert property (@(posedge clock) disable iff (!rst_n)
        (ctrl.pc_sel == PC_BRANCH) |-> (out_valid && $past(in_valid && is_branch)))
        else $error("ctrl_issue_stage: PC_BRANCH without a valid branch");

    // Ebreak relies on the table entry decoding to an all-zero word
    a_ebreak_word: assert property (@(posedge clock) disable iff (!rst_n)
        is_ebreak |-> (out_valid && ctrl == '0))
        else $error("ctrl_issue_stage: ebreak with out_valid %b ctrl %h", out_valid, ctrl);

endmodule

/* design/ctrl_rom.sv */
// Control table matching a 17-bit key against 26 entries and returning the control word
`timescale 1ns/1ps

module ctrl_rom
    import rv_decode_pkg::*;
(
    input  logic               clock,
    input  logic               rst_n,
    input  logic [KEY_LEN-1:0] key,
    output ctrl_t              table_ctrl
);

    // Packs one row, memory enables stay low since loads and stores are absent
    function automatic logic [ROW_LEN-1:0] row(
        input logic [6:0] opc,
        input logic [2:0] f3,
        input logic [6:0] f7,
        input logic [4:0] alu,
        input logic [1:0] op1,
        input logic [1:0] op2,
        input logic [2:0] pc,
        input logic       we,
        input logic [1:0] wb
    );
        return {opc, f3, f7, alu, op1, op2, pc, we, 1'b0, 1'b0, wb};
    endfunction

    localparam logic [ROW_LEN-1:0] ROM [NR_KEY] = '{
        // R-type
        row(OPC_OP, 3'b000, F7_ZERO, ALU_ADD, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),  // ADD
        row(OPC_OP, 3'b000, F7_ALT, ALU_SUB, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),   // SUB
        row(OPC_OP, 3'b001, F7_ZERO, ALU_SLL, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),  // SLL
        row(OPC_OP, 3'b010, F7_ZERO, ALU_SLT, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP, 3'b011, F7_ZERO, ALU_SLTU, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP, 3'b100, F7_ZERO, ALU_XOR, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP, 3'b101, F7_ZERO, ALU_SRL, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),  // SRL
        row(OPC_OP, 3'b101, F7_ALT, ALU_SRA, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),   // SRA
        row(OPC_OP, 3'b110, F7_ZERO, ALU_OR, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP, 3'b111, F7_ZERO, ALU_AND, OP_RS, OP_RS2, PC_SEQ, 1'b1, WB_ALU),
        // I-type
        row(OPC_OP_IMM, 3'b000, F7_ZERO, ALU_ADD, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b010, F7_ZERO, ALU_SLT, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b011, F7_ZERO, ALU_SLTU, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b100, F7_ZERO, ALU_XOR, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b110, F7_ZERO, ALU_OR, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b111, F7_ZERO, ALU_AND, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b001, F7_ZERO, ALU_SLL, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b101, F7_ZERO, ALU_SRL, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_OP_IMM, 3'b101, F7_ALT, ALU_SRA, OP_RS, OP_IMM, PC_SEQ, 1'b1, WB_ALU),
        // Branches, taken path is patched in the issue stage
        row(OPC_BRANCH, F3_BEQ, F7_ZERO, ALU_ADD, OP_RS, OP_RS, PC_SEQ, 1'b0, WB_NONE),
        row(OPC_BRANCH, F3_BLT, F7_ZERO, ALU_ADD, OP_RS, OP_RS, PC_SEQ, 1'b0, WB_NONE),
        row(OPC_BRANCH, F3_BLTU, F7_ZERO, ALU_ADD, OP_RS, OP_RS, PC_SEQ, 1'b0, WB_NONE),
        // Jumps and upper immediate
        row(OPC_JAL, 3'b000, F7_ZERO, ALU_ADD, OP_RS, OP_RS, PC_JAL, 1'b1, WB_PC4),
        row(OPC_AUIPC, 3'b000, F7_ZERO, ALU_ADD, OP_PC, OP_RS, PC_SEQ, 1'b1, WB_ALU),
        row(OPC_JALR, 3'b000, F7_ZERO, ALU_ADD, OP_RS, OP_IMM, PC_JALR, 1'b1, WB_PC4),
        // Ebreak itself is flagged by a full-word compare downstream
        row(OPC_SYSTEM, 3'b000, F7_ZERO, ALU_ADD, OP_RS, OP_RS, PC_SEQ, 1'b0, WB_NONE)
    };

    logic [NR_KEY-1:0]   hit;                           // One bit per entry
    logic [CTRL_LEN-1:0] ctrl_acc;                      // OR of matching rows

    always_comb begin
        ctrl_acc = '0;                                  // Unknown key decodes to zero
        for (int k = 0; k < NR_KEY; k++) begin
            hit[k] = (key == ROM[k][ROW_LEN-1 -: KEY_LEN]);
            if (hit[k]) begin
                ctrl_acc = ctrl_acc | ROM[k][CTRL_LEN-1:0];
            end
        end
    end

    assign table_ctrl = ctrl_t'(ctrl_acc);

    // Overlapping keys would silently merge two control words
    a_unique_hit: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(hit))
        else $error("ctrl_rom: key %h matches entries %b", key, hit);

endmodule

/* design/inst_key_gen.sv */
// Lookup key builder folding opcode, funct3 and funct7 into one table key
`timescale 1ns/1ps

module inst_key_gen
    import rv_decode_pkg::*;
(
    input  inst_t              inst,
    output logic [KEY_LEN-1:0] key
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = inst.r.opcode;
    assign funct3 = inst.r.funct3;
    assign funct7 = inst.r.funct7;                      // Register ops and shift type

    always_comb begin
        case (opcode)
            OPC_JALR: begin
                // Only funct3 000 is a real JALR
                if (inst.i.funct3 == 3'b000) begin
                    key = {OPC_JALR, 3'b000, F7_ZERO};
                end else begin
                    key = {OPC_JALR, inst.i.funct3, ~F7_ZERO};  // Hits no entry
                end
            end
            OPC_OP_IMM: begin
                if (inst.i.funct3 == 3'b101) begin
                    key = {opcode, inst.i.funct3, inst.i.imm12[11:5]};  // SRLI vs SRAI
                end else begin
                    key = {opcode, inst.i.funct3, F7_ZERO};  // Upper bits are immediate
                end
            end
            OPC_AUIPC,
            OPC_JAL: begin
                key = {opcode, 3'b000, F7_ZERO};        // No function fields
            end
            default: begin
                key = {opcode, funct3, funct7};         // R-type, branch, system
            end
        endcase
    end

endmodule

/* design/rv_decode_pkg.sv */
// Decoder widths, RV32I opcode and field constants, control encodings, instruction and control types
package rv_decode_pkg;

    localparam int XLEN     = 32;                       // Instruction word width
    localparam int KEY_LEN  = 17;                       // {opcode, funct3, funct7}
    localparam int CTRL_LEN = 17;                       // Width of ctrl_t
    localparam int NR_KEY   = 26;                       // Control table entries
    localparam int ROW_LEN  = KEY_LEN + CTRL_LEN;       // One table row, key above control

    // Major opcodes handled by the table
    localparam logic [6:0] OPC_OP     = 7'b0110011;     // R-type ALU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;     // I-type ALU and shifts
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;     // Only ebreak is decoded

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BLTU = 3'b110;

    localparam logic [6:0] F7_ZERO = 7'b0000000;        // Base encoding
    localparam logic [6:0] F7_ALT  = 7'b0100000;        // SUB, SRA, SRAI

    // ALU operations
    localparam logic [4:0] ALU_ADD  = 5'b00000;
    localparam logic [4:0] ALU_SUB  = 5'b00001;
    localparam logic [4:0] ALU_SLT  = 5'b00010;
    localparam logic [4:0] ALU_SLTU = 5'b00011;
    localparam logic [4:0] ALU_XOR  = 5'b00100;
    localparam logic [4:0] ALU_OR   = 5'b00101;
    localparam logic [4:0] ALU_AND  = 5'b00110;
    localparam logic [4:0] ALU_SLL  = 5'b00111;
    localparam logic [4:0] ALU_SRL  = 5'b01000;
    localparam logic [4:0] ALU_SRA  = 5'b01001;

    localparam logic [2:0] PC_SEQ    = 3'd0;            // pc + 4
    localparam logic [2:0] PC_JALR   = 3'd1;            // rs1 + imm
    localparam logic [2:0] PC_BRANCH = 3'd2;            // Taken branch target
    localparam logic [2:0] PC_JAL    = 3'd3;

    localparam logic [1:0] WB_NONE = 2'd0;
    localparam logic [1:0] WB_PC4  = 2'd1;              // Link address
    localparam logic [1:0] WB_ALU  = 2'd2;

    // Operand selects; OP_RS doubles as "operand unused"
    localparam logic [1:0] OP_RS  = 2'd0;
    localparam logic [1:0] OP_PC  = 2'd1;               // Operand 1 only
    localparam logic [1:0] OP_IMM = 2'd1;               // Operand 2 only
    localparam logic [1:0] OP_RS2 = 2'd3;

    localparam logic [XLEN-1:0] EBREAK_WORD = 32'h00100073;

    // Same word seen as R-format or I-format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm12;                         // Upper 7 bits hold shift type
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
    } inst_t;

    // Field order follows the control table, alu_op at the top
    typedef struct packed {
        logic [4:0] alu_op;
        logic [1:0] op1_sel;
        logic [1:0] op2_sel;
        logic [2:0] pc_sel;
        logic       rf_we;
        logic       mem_en;
        logic       mem_wen;
        logic [1:0] wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic eq;                                       // rs1 == rs2
        logic lt;                                       // Signed rs1 < rs2
        logic ltu;                                      // Unsigned rs1 < rs2
    } br_flags_t;

endpackage

/* design/rv_decode_top.sv */
// Top level of the registered RV32I decoder, key builder feeding table feeding issue stage
`timescale 1ns/1ps

module rv_decode_top
    import rv_decode_pkg::*;
(
    input  logic      clock,
    input  logic      rst_n,
    input  logic      in_valid,                         // One instruction per cycle
    input  inst_t     inst,
    input  br_flags_t br,                               // Compare results for this inst
    output logic      out_valid,                        // One cycle after in_valid
    output ctrl_t     ctrl,
    output logic      is_ebreak
);

    logic [KEY_LEN-1:0] key;                            // Combinational lookup key
    ctrl_t              table_ctrl;                     // Raw table word

    inst_key_gen u_key_gen (
        .inst (inst),
        .key  (key)
    );

    ctrl_rom u_ctrl_rom (
        .clock      (clock),
        .rst_n      (rst_n),
        .key        (key),
        .table_ctrl (table_ctrl)
    );

    // Only registered stage in the path
    ctrl_issue_stage u_issue (
        .clock      (clock),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .inst       (inst),
        .br         (br),
        .table_ctrl (table_ctrl),
        .out_valid  (out_valid),
        .ctrl       (ctrl),
        .is_ebreak  (is_ebreak)
    );

endmodule

/* rv_decode_top.f */
design/rv_decode_pkg.sv
design/inst_key_gen.sv
design/ctrl_rom.sv
design/ctrl_issue_stage.sv
design/rv_decode_top.sv
verification/tb_clock_gen.sv
verification/tb_rv_decode_top.sv

/* verification/tb_clock_gen.sv */
// Testbench clock source and power-on reset generator
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic rst_n
);

    localparam real HALF_PERIOD_NS = 4.0;               // 8 ns clock
    localparam int  RESET_CYCLES   = 8;

    initial begin
        clock = 1'b0;
        forever begin
            #(HALF_PERIOD_NS) clock = ~clock;
        end
    end

    initial begin
        rst_n = 1'b0;                                   // Held from time zero
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);                               // Release away from the active edge
        rst_n <= 1'b1;
    end

endmodule

/* verification/tb_rv_decode_top.sv */
// Table-driven testbench for the registered RV32I decoder with compare tasks and final report
`timescale 1ns/1ps

module tb_rv_decode_top
    import rv_decode_pkg::*;
();

    localparam int RESET_TIMEOUT = 64;                  // Cycles allowed for reset release

    typedef struct packed {
        inst_t     inst;
        br_flags_t br;
        ctrl_t     exp_ctrl;
        logic      exp_ebreak;
    } row_t;

    typedef struct packed {
        logic  valid;
        ctrl_t ctrl;
        logic  ebreak;
    } result_t;

    logic      clock;
    logic      rst_n;
    logic      in_valid;
    inst_t     inst;
    br_flags_t br;
    logic      out_valid;
    ctrl_t     ctrl;
    logic      is_ebreak;

    row_t    rows[$];                                   // Stimulus and expected values
    string   row_names[$];
    result_t pending;                                   // Due at the next sample point
    string   pending_name;
    int      errors;
    int      checks;
    integer  seed;

    tb_clock_gen u_clk (
        .clock (clock),
        .rst_n (rst_n)
    );

    rv_decode_top dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .inst      (inst),
        .br        (br),
        .out_valid (out_valid),
        .ctrl      (ctrl),
        .is_ebreak (is_ebreak)
    );

    function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                    input logic [6:0] opc);
        return inst_t'({f7, 5'd2, 5'd1, f3, 5'd3, opc});  // rs2 x2, rs1 x1, rd x3
    endfunction

    function automatic inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                    input logic [6:0] opc);
        return inst_t'({imm, 5'd5, f3, 5'd6, opc});
    endfunction

    // Branch offset kept below bit 5 so the funct7 slot stays zero
    function automatic inst_t enc_b(input logic [2:0] f3);
        return inst_t'({7'h00, 5'd2, 5'd1, f3, 5'b01000, OPC_BRANCH});
    endfunction

    function automatic ctrl_t make_ctrl(input logic [4:0] alu, input logic [1:0] op1,
                                        input logic [1:0] op2, input logic [2:0] pc,
                                        input logic we, input logic [1:0] wb);
        ctrl_t c;
        c         = '0;                                 // Memory enables never set
        c.alu_op  = alu;
        c.op1_sel = op1;
        c.op2_sel = op2;
        c.pc_sel  = pc;
        c.rf_we   = we;
        c.wb_sel  = wb;
        return c;
    endfunction

    function automatic br_flags_t flags(input logic eq, input logic lt, input logic ltu);
        br_flags_t f;
        f.eq  = eq;
        f.lt  = lt;
        f.ltu = ltu;
        return f;
    endfunction

    task automatic add_row(input string name, input inst_t i, input br_flags_t b,
                           input ctrl_t c, input logic e);
        row_t r;
        r.inst       = i;
        r.br         = b;
        r.exp_ctrl   = c;
        r.exp_ebreak = e;
        rows.push_back(r);
        row_names.push_back(name);
    endtask

    // Register-writing ALU op, operand 1 from rs1
    task automatic add_alu(input string name, input inst_t i, input logic [4:0] alu,
                           input logic [1:0] op2);
        add_row(name, i, flags(1'b1, 1'b0, 1'b1),
                make_ctrl(alu, OP_RS, op2, PC_SEQ, 1'b1, WB_ALU), 1'b0);
    endtask

    task automatic build_table();
        ctrl_t taken;
        ctrl_t not_taken;
        taken     = make_ctrl(ALU_ADD, OP_RS, OP_RS, PC_BRANCH, 1'b0, WB_NONE);
        not_taken = make_ctrl(ALU_ADD, OP_RS, OP_RS, PC_SEQ, 1'b0, WB_NONE);
        add_alu("add", enc_r(7'h00, 3'b000, OPC_OP), ALU_ADD, OP_RS2);
        add_alu("sub", enc_r(7'h20, 3'b000, OPC_OP), ALU_SUB, OP_RS2);
        add_alu("sll", enc_r(7'h00, 3'b001, OPC_OP), ALU_SLL, OP_RS2);
        add_alu("slt", enc_r(7'h00, 3'b010, OPC_OP), ALU_SLT, OP_RS2);
        add_alu("sltu", enc_r(7'h00, 3'b011, OPC_OP), ALU_SLTU, OP_RS2);
        add_alu("xor", enc_r(7'h00, 3'b100, OPC_OP), ALU_XOR, OP_RS2);
        add_alu("srl", enc_r(7'h00, 3'b101, OPC_OP), ALU_SRL, OP_RS2);
        add_alu("sra", enc_r(7'h20, 3'b101, OPC_OP), ALU_SRA, OP_RS2);
        add_alu("or", enc_r(7'h00, 3'b110, OPC_OP), ALU_OR, OP_RS2);
        add_alu("and", enc_r(7'h00, 3'b111, OPC_OP), ALU_AND, OP_RS2);
        add_alu("addi", enc_i(12'hfff, 3'b000, OPC_OP_IMM), ALU_ADD, OP_IMM);  // Imm top bits set
        add_alu("slti", enc_i(12'h800, 3'b010, OPC_OP_IMM), ALU_SLT, OP_IMM);
        add_alu("sltiu", enc_i(12'h801, 3'b011, OPC_OP_IMM), ALU_SLTU, OP_IMM);
        add_alu("xori", enc_i(12'h5a5, 3'b100, OPC_OP_IMM), ALU_XOR, OP_IMM);
        add_alu("ori", enc_i(12'hf0f, 3'b110, OPC_OP_IMM), ALU_OR, OP_IMM);
        add_alu("andi", enc_i(12'h0ff, 3'b111, OPC_OP_IMM), ALU_AND, OP_IMM);
        add_alu("slli", enc_i({7'h00, 5'd7}, 3'b001, OPC_OP_IMM), ALU_SLL, OP_IMM);
        add_alu("srli", enc_i({7'h00, 5'd9}, 3'b101, OPC_OP_IMM), ALU_SRL, OP_IMM);
        add_alu("srai", enc_i({7'h20, 5'd9}, 3'b101, OPC_OP_IMM), ALU_SRA, OP_IMM);
        // JAL keeps offset bits in its funct3 slot
        add_row("jal", inst_t'({20'hfedcb, 5'd1, OPC_JAL}), flags(1'b0, 1'b0, 1'b0),
                make_ctrl(ALU_ADD, OP_RS, OP_RS, PC_JAL, 1'b1, WB_PC4), 1'b0);
        add_row("jalr", enc_i(12'h010, 3'b000, OPC_JALR), flags(1'b1, 1'b1, 1'b1),
                make_ctrl(ALU_ADD, OP_RS, OP_IMM, PC_JALR, 1'b1, WB_PC4), 1'b0);
        add_row("jalr f3=2", enc_i(12'h010, 3'b010, OPC_JALR), flags(1'b0, 1'b0, 1'b0),
                '0, 1'b0);                              // Reserved funct3
        add_row("auipc", inst_t'({20'h12345, 5'd4, OPC_AUIPC}), flags(1'b0, 1'b0, 1'b0),
                make_ctrl(ALU_ADD, OP_PC, OP_RS, PC_SEQ, 1'b1, WB_ALU), 1'b0);
        // Each branch follows its own flag only
        add_row("beq taken", enc_b(F3_BEQ), flags(1'b1, 1'b0, 1'b0), taken, 1'b0);
        add_row("beq all set", enc_b(F3_BEQ), flags(1'b1, 1'b1, 1'b1), taken, 1'b0);
        add_row("beq not taken", enc_b(F3_BEQ), flags(1'b0, 1'b1, 1'b1), not_taken, 1'b0);
        add_row("blt taken", enc_b(F3_BLT), flags(1'b0, 1'b1, 1'b0), taken, 1'b0);
        add_row("blt not taken", enc_b(F3_BLT), flags(1'b1, 1'b0, 1'b1), not_taken, 1'b0);
        add_row("blt all set", enc_b(F3_BLT), flags(1'b1, 1'b1, 1'b1), taken, 1'b0);
        add_row("bltu taken", enc_b(F3_BLTU), flags(1'b0, 1'b0, 1'b1), taken, 1'b0);
        add_row("bltu not taken", enc_b(F3_BLTU), flags(1'b1, 1'b1, 1'b0), not_taken, 1'b0);
        add_row("bne", enc_b(3'b001), flags(1'b0, 1'b1, 1'b1), '0, 1'b0);  // Not in table
        // System space and unknown opcodes
        add_row("ebreak", inst_t'(32'h00100073), flags(1'b1, 1'b1, 1'b1), '0, 1'b1);
        add_row("ebreak rd=1", inst_t'(32'h001000f3), flags(1'b0, 1'b0, 1'b0), '0, 1'b0);
        add_row("ecall", inst_t'(32'h00000073), flags(1'b0, 1'b0, 1'b0), '0, 1'b0);
        add_row("lw", inst_t'(32'h0002a303), flags(1'b0, 1'b0, 1'b0), '0, 1'b0);
        add_row("all ones", inst_t'(32'hffffffff), flags(1'b1, 1'b1, 1'b1), '0, 1'b0);
    endtask

    task automatic check_ctrl(input ctrl_t got, input ctrl_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s ctrl got %h expected %h (alu %h/%h pc_sel %0d/%0d)",
                     $time, what, got, exp, got.alu_op, exp.alu_op, got.pc_sel, exp.pc_sel);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_result(input string name);
        check_flag(out_valid, pending.valid, {name, " out_valid"});
        check_ctrl(ctrl, pending.ctrl, name);
        check_flag(is_ebreak, pending.ebreak, {name, " is_ebreak"});
    endtask

    // Drives one cycle and checks the item driven the cycle before
    task automatic apply_cycle(input logic valid, input row_t r, input string name);
        logic [31:0] junk;
        junk = $random(seed);                           // Bus noise while idle
        @(posedge clock);
        in_valid <= valid;
        inst     <= valid ? r.inst : inst_t'(junk);
        br       <= valid ? r.br : br_flags_t'(junk[2:0]);
        @(negedge clock);                               // Outputs settled mid-cycle
        check_result(pending_name);
        pending.valid  = valid;
        pending.ctrl   = valid ? r.exp_ctrl : ctrl_t'('0);
        pending.ebreak = valid & r.exp_ebreak;
        pending_name   = valid ? name : "idle";
    endtask

    initial begin : main
        int          wait_cnt;
        int          idle_n;
        logic [31:0] rnd;
        row_t        idle_row;
        seed         = 32'h808bb574;
        errors       = 0;
        checks       = 0;
        in_valid     = 1'b0;
        inst         = '0;
        br           = '0;
        idle_row     = '0;
        pending      = '0;                              // Reset state with all outputs low
        pending_name = "after reset";
        build_table();
        @(posedge clock);
        in_valid <= 1'b1;                               // Live inputs only reset holds off
        inst     <= rows[0].inst;
        @(posedge clock);
        inst     <= inst_t'(32'h00100073);
        @(negedge clock);
        check_result("in reset add");
        @(posedge clock);
        in_valid <= 1'b0;
        @(negedge clock);
        check_result("in reset ebreak");
        wait_cnt = 0;
        while (rst_n !== 1'b1 && wait_cnt < RESET_TIMEOUT) begin
            @(posedge clock);
            wait_cnt++;
        end
        if (rst_n !== 1'b1) begin
            $display("Reset was not released within %0d clock cycles", RESET_TIMEOUT);
            $display("TESTS FAILED");
            $finish;
        end else begin
            @(negedge clock);
            check_result(pending_name);
            for (int i = 0; i < rows.size(); i++) begin
                apply_cycle(1'b1, rows[i], row_names[i]);
                rnd    = $random(seed);
                idle_n = (rnd[1:0] == 2'b11) ? 2 : ((rnd[1:0] == 2'b10) ? 1 : 0);
                repeat (idle_n) apply_cycle(1'b0, idle_row, "idle");
            end
            apply_cycle(1'b0, idle_row, "idle");        // Drains the last row
            apply_cycle(1'b0, idle_row, "idle");        // Idle result itself
            $display("Decoder rows: %0d, checks: %0d, errors: %0d",
                     rows.size(), checks, errors);
            if (errors == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule
